// File: flist.f
+incdir+include
design/fc_pkg.sv
design/fc_skew_line.sv
design/weight_bank.sv
design/fc_weight_buf.sv
design/fc_mac_row.sv
design/fc_layer.sv
test/fc_layer_asserts.sv
test/fc_layer_tb.sv

// File: Makefile
TOP := fc_layer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

# the pipe status is grep's, so a missing pass line fails the target.
sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^Everything OK$$'

clean:
	rm -rf obj_dir

// File: test/fc_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

module fc_layer_tb import fc_pkg::*; ();

    localparam int NL    = `FC_NUM_LANES;
    localparam int DEPTH = `FC_BANK_DEPTH;
    localparam int VLEN  = 16;
    // reset, weight loads, all bursts with their latency, then slack.
    localparam int RUN_CYCLES = 16 + NL * VLEN + 3 + 6 * VLEN + 6 * (NL + 10) + 100;

    logic        clk;
    logic        rst_all;
    wr_req_t     wr_i;
    rd_req_t     rd_i;
    act_t        act_i;
    sum_vec_t    sum_o;
    logic        done_o;

    weight_t     ref_w [NL][DEPTH];   // mirror of every bank write.
    logic [15:0] lfsr_state = 16'd14708;
    int unsigned cyc;
    int unsigned done_cyc [$];
    sum_vec_t    done_sum [$];

    fc_layer i_dut (
        .clk     (clk),
        .rst_all (rst_all),
        .wr_i    (wr_i),
        .rd_i    (rd_i),
        .act_i   (act_i),
        .sum_o   (sum_o),
        .done_o  (done_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // record each done pulse with the sums it presents.
    always @(negedge clk) begin
        if (rst_all && done_o) begin
            done_cyc.push_back(cyc);
            done_sum.push_back(sum_o);
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic acc_t dot_product(input int lane, input int rows[$], input act_t acts[$]);
        int s;
        s = 0;
        foreach (rows[k]) begin
            s += int'(ref_w[lane][rows[k]]) * int'(acts[k]);
        end
        return acc_t'(s);
    endfunction

    task automatic fail_and_stop();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_i  <= '0;
            rd_i  <= '0;
            act_i <= '0;
        end
    endtask

    task automatic write_weight(input int bank, input int row, input weight_t data);
        logic [`FC_WADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[`FC_SEL_LSB +: `FC_SEL_WIDTH] = bank[`FC_SEL_WIDTH-1:0];
        addr[`FC_PTR_WIDTH-1:0] = row[`FC_PTR_WIDTH-1:0];
        @(posedge clk);
        wr_i <= '{strobe: 1'b1, addr: addr, data: data};
        if (bank < NL) ref_w[bank][row] = data;   // out-of-range banks drop the write.
    endtask

    task automatic drive_vector(input int rows[$], input act_t acts[$],
                                output int unsigned last_cyc);
        foreach (rows[k]) begin
            @(posedge clk);
            rd_i  <= '{strobe: 1'b1, ptr: ptr_t'(rows[k]), first: (k == 0),
                       last: (k == rows.size() - 1)};
            act_i <= acts[k];
            last_cyc = cyc + 1;   // cycle number seen while this element is on rd_i.
        end
    endtask

    task automatic wait_dones(input int n);
        int guard;
        guard = 0;
        while (done_cyc.size() < n) begin
            @(negedge clk);
            guard++;
            if (guard > 4 * VLEN + NL) begin
                $display("no done_o pulse arrived within the expected time");
                fail_and_stop();
            end
        end
    endtask

    task automatic check_sums(input int idx, input int rows[$], input act_t acts[$]);
        for (int i = 0; i < NL; i++) begin
            check_value($sformatf("sum_o[%0d]", i), longint'(done_sum[idx][i]),
                        longint'(dot_product(i, rows, acts)));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        repeat (8) begin
            @(negedge clk);
            check_value("done_o", longint'(done_o), 64'd0);
            for (int i = 0; i < NL; i++) begin
                check_value($sformatf("sum_o[%0d]", i), longint'(sum_o[i]), 64'd0);
            end
        end
    endtask

    task automatic test_random_vector();
        int          rows[$];
        act_t        acts[$];
        int unsigned last_cyc;
        int          base;
        for (int b = 0; b < NL; b++) begin
            for (int r = 0; r < VLEN; r++) begin
                write_weight(b, r, weight_t'(rand_byte()));
            end
        end
        go_idle(2);
        for (int r = 0; r < VLEN; r++) begin
            rows.push_back(r);
            acts.push_back(act_t'(rand_byte()));
        end
        base = done_cyc.size();
        drive_vector(rows, acts, last_cyc);
        go_idle(1);
        wait_dones(base + 1);
        check_value("done_o latency", longint'(done_cyc[base] - last_cyc), longint'(NL + 2));
        check_sums(base, rows, acts);
    endtask

    // a single 1 picks out one stored row in every lane.
    task automatic run_one_hot(input int hot_row);
        int          rows[$];
        act_t        acts[$];
        int unsigned last_cyc;
        int          base;
        for (int r = 0; r < VLEN; r++) begin
            rows.push_back(r);
            acts.push_back((r == hot_row) ? act_t'(1) : act_t'(0));
        end
        base = done_cyc.size();
        drive_vector(rows, acts, last_cyc);
        go_idle(1);
        wait_dones(base + 1);
        check_value("done_o latency", longint'(done_cyc[base] - last_cyc), longint'(NL + 2));
        for (int i = 0; i < NL; i++) begin
            check_value($sformatf("sum_o[%0d]", i), longint'(done_sum[base][i]),
                        longint'(ref_w[i][hot_row]));
        end
    endtask

    task automatic test_back_to_back();
        int          rows_a[$];
        int          rows_b[$];
        act_t        acts_a[$];
        act_t        acts_b[$];
        int unsigned last_a;
        int unsigned last_b;
        int          base;
        for (int r = 0; r < VLEN; r++) begin
            rows_a.push_back(r);
            acts_a.push_back(act_t'(rand_byte()));
        end
        for (int r = VLEN - 1; r >= 6; r--) begin   // shorter, walking down.
            rows_b.push_back(r);
            acts_b.push_back(act_t'(rand_byte()));
        end
        base = done_cyc.size();
        drive_vector(rows_a, acts_a, last_a);
        drive_vector(rows_b, acts_b, last_b);
        go_idle(1);
        wait_dones(base + 2);
        check_value("done_o latency", longint'(done_cyc[base + 1] - last_b), longint'(NL + 2));
        check_value("done_o spacing", longint'(done_cyc[base + 1] - done_cyc[base]),
                    longint'(rows_b.size()));
        check_sums(base, rows_a, acts_a);
        check_sums(base + 1, rows_b, acts_b);
    endtask

    // bank fields 8, 11 and 127 alias banks 0, 3 and 7 in their low bits.
    task automatic test_bad_bank();
        write_weight(NL, 9, ~ref_w[0][9]);
        write_weight(NL + 3, 9, ~ref_w[3][9]);
        write_weight(127, 9, ~ref_w[7][9]);
        go_idle(2);
        run_one_hot(9);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_all   <= 1'b0;
        wr_i      <= '0;
        rd_i      <= '0;
        act_i     <= '0;
        repeat (16) @(posedge clk);
        rst_all <= 1'b1;

        test_reset_idle();
        test_random_vector();
        run_one_hot(9);
        run_one_hot(2);
        test_back_to_back();
        test_bad_bank();
        go_idle(4);

        $display("Everything OK");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 10);
        $display("watchdog expired before the tests finished");
        fail_and_stop();
    end

endmodule

`default_nettype wire

// File: test/fc_layer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

module fc_layer_asserts import fc_pkg::*; (
    input wire                     clk,
    input wire                     rst_all,
    input wr_req_t                 wr_i,
    input rd_req_t                 rd_i,
    input rd_req_t                 rd_taps [`FC_NUM_LANES-1],
    input wire [`FC_NUM_LANES-1:0] cap_en,
    input wire                     done_o
);

    logic rd_busy;   // a read is still walking through the banks.

    always_comb begin
        rd_busy = rd_i.strobe;
        for (int k = 0; k < `FC_NUM_LANES - 1; k++) begin
            rd_busy = rd_busy | rd_taps[k].strobe;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!rst_all) done_o |=> !done_o)
        else $error("done_o high for two cycles in a row");

    no_write_in_burst: assert property (@(posedge clk) disable iff (!rst_all)
        !(wr_i.strobe && rd_busy))
        else $error("weight write while a read burst is in flight");

    // all lanes have landed once done_o is seen.
    no_late_capture: assert property (@(posedge clk) disable iff (!rst_all)
        done_o |=> (cap_en == '0))
        else $error("lane capture still pending after done_o");

endmodule

bind fc_layer fc_layer_asserts i_asserts (
    .clk     (clk),
    .rst_all (rst_all),
    .wr_i    (wr_i),
    .rd_i    (rd_i),
    .rd_taps (i_weight_buf.rd_taps),
    .cap_en  (i_mac_row.cap_en),
    .done_o  (done_o)
);

`default_nettype wire

// File: design/fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

module fc_layer import fc_pkg::*; (
    input  wire      clk,
    input  wire      rst_all,
    input  wr_req_t  wr_i,
    input  rd_req_t  rd_i,
    input  act_t     act_i,
    output sum_vec_t sum_o,
    output logic     done_o
);

    weight_vec_t weights;
    act_req_t    act_req;

    // activation rides with the read flags.
    assign act_req = '{
        act:    act_i,
        strobe: rd_i.strobe,
        first:  rd_i.first,
        last:   rd_i.last
    };

    fc_weight_buf i_weight_buf (
        .clk       (clk),
        .rst_all   (rst_all),
        .wr_i      (wr_i),
        .rd_i      (rd_i),
        .weights_o (weights)
    );

    fc_mac_row i_mac_row (
        .clk       (clk),
        .rst_all   (rst_all),
        .act_i     (act_req),
        .weights_i (weights),
        .sum_o     (sum_o),
        .done_o    (done_o)
    );

endmodule

`default_nettype wire

// File: design/fc_mac_row.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

module fc_mac_row import fc_pkg::*; (
    input  wire         clk,
    input  wire         rst_all,
    input  act_req_t    act_i,
    input  weight_vec_t weights_i,
    output sum_vec_t    sum_o,
    output logic        done_o
);

    localparam int NL = `FC_NUM_LANES;

    // tap i feeds lane i, tap i+1 tells lane i to capture.
    act_req_t act_taps [NL+1];

    fc_skew_line #(
        .item_t (act_req_t),
        .DEPTH  (NL + 1)
    ) i_act_skew (
        .clk     (clk),
        .rst_all (rst_all),
        .d_i     (act_i),
        .taps_o  (act_taps)
    );

    ////////////////////////////////////////////////////////////
    // per-lane multiply
    ////////////////////////////////////////////////////////////

    acc_t            prod [NL];
    acc_t            acc  [NL];
    logic [NL-1:0]   cap_en;

    for (genvar i = 0; i < NL; i++) begin : g_lane
        weight_t w;
        act_t    a;

        assign w = weights_i[i];
        assign a = act_taps[i].act;
        assign prod[i] = acc_t'(w) * acc_t'(a);   // sign-extended product.

        assign cap_en[i] = act_taps[i+1].strobe && act_taps[i+1].last;
    end

    ////////////////////////////////////////////////////////////
    // accumulate and deskew
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < NL; i++) begin
            if (act_taps[i].strobe) begin
                acc[i] <= act_taps[i].first ? prod[i] : acc[i] + prod[i];
            end
        end
    end

    // lanes land one per cycle, lane NL-1 completes the word.
    always_ff @(posedge clk) begin
        if (!rst_all) begin
            sum_o  <= '0;
            done_o <= 1'b0;
        end else begin
            for (int i = 0; i < NL; i++) begin
                if (cap_en[i]) begin
                    sum_o[i] <= acc[i];
                end
            end
            done_o <= cap_en[NL-1];
        end
    end

endmodule

`default_nettype wire

// File: design/fc_weight_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

module fc_weight_buf import fc_pkg::*; (
    input  wire         clk,
    input  wire         rst_all,
    input  wr_req_t     wr_i,
    input  rd_req_t     rd_i,
    output weight_vec_t weights_o
);

    localparam int NL = `FC_NUM_LANES;

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////

    logic [`FC_SEL_WIDTH-1:0] wr_sel;
    ptr_t                     wr_row;

    assign wr_sel = wr_i.addr[`FC_SEL_LSB +: `FC_SEL_WIDTH];
    assign wr_row = wr_i.addr[`FC_PTR_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // read wavefront
    ////////////////////////////////////////////////////////////

    rd_req_t rd_taps [NL-1];
    rd_req_t rd_lane [NL];   // request seen by each bank.

    fc_skew_line #(
        .item_t (rd_req_t),
        .DEPTH  (NL - 1)
    ) i_rd_skew (
        .clk     (clk),
        .rst_all (rst_all),
        .d_i     (rd_i),
        .taps_o  (rd_taps)
    );

    always_comb begin
        rd_lane[0] = rd_i;
        for (int i = 1; i < NL; i++) begin
            rd_lane[i] = rd_taps[i-1];   // bank i lags by i cycles.
        end
    end

    ////////////////////////////////////////////////////////////
    // bank array
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NL; i++) begin : g_bank
        logic bank_we;
        ptr_t bank_addr;

        assign bank_we   = wr_i.strobe && (wr_sel == `FC_SEL_WIDTH'(i));
        assign bank_addr = rd_lane[i].strobe ? rd_lane[i].ptr : wr_row;

        weight_bank #(
            .DEPTH (`FC_BANK_DEPTH)
        ) i_bank (
            .clk     (clk),
            .rst_all (rst_all),
            .en_i    (rd_lane[i].strobe || bank_we),
            .we_i    (bank_we),
            .addr_i  (bank_addr),
            .wdata_i (wr_i.data),
            .rdata_o (weights_o[i])
        );
    end

endmodule

`default_nettype wire

// File: design/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

// single-port ram, read-first.
module weight_bank import fc_pkg::*; #(
    parameter int DEPTH = `FC_BANK_DEPTH
) (
    input  wire     clk,
    input  wire     rst_all,
    input  wire     en_i,
    input  wire     we_i,
    input  ptr_t    addr_i,
    input  weight_t wdata_i,
    output weight_t rdata_o
);

    weight_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // old contents come out on a write cycle.
    always_ff @(posedge clk) begin
        if (!rst_all) begin
            rdata_o <= '0;
        end else if (en_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: design/fc_skew_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_consts.svh"

// shift chain, every stage is a tap.
// tap k carries d_i delayed by k+1 cycles.
module fc_skew_line import fc_pkg::*; #(
    parameter type item_t = rd_req_t,
    parameter int  DEPTH  = `FC_NUM_LANES - 1
) (
    input  wire   clk,
    input  wire   rst_all,
    input  item_t d_i,
    output item_t taps_o [DEPTH]
);

    always_ff @(posedge clk) begin
        if (!rst_all) begin
            for (int k = 0; k < DEPTH; k++) begin
                taps_o[k] <= '0;   // clears strobes too.
            end
        end else begin
            taps_o[0] <= d_i;
            for (int k = 1; k < DEPTH; k++) begin
                taps_o[k] <= taps_o[k-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fc_pkg.sv
`default_nettype none

package fc_pkg;

    `include "fc_consts.svh"

    typedef logic signed [`FC_W_WIDTH-1:0]   weight_t;
    typedef logic signed [`FC_W_WIDTH-1:0]   act_t;
    typedef logic        [`FC_PTR_WIDTH-1:0] ptr_t;
    typedef logic signed [`FC_ACC_WIDTH-1:0] acc_t;

    typedef struct packed {
        logic                       strobe;
        logic [`FC_WADDR_WIDTH-1:0] addr;   // bank in upper field, row in low bits.
        weight_t                    data;
    } wr_req_t;

    typedef struct packed {
        logic strobe;
        ptr_t ptr;
        logic first;   // start a new sum.
        logic last;    // end of this vector.
    } rd_req_t;

    typedef struct packed {
        act_t act;
        logic strobe;
        logic first;
        logic last;
    } act_req_t;

    typedef acc_t    [`FC_NUM_LANES-1:0] sum_vec_t;
    typedef weight_t [`FC_NUM_LANES-1:0] weight_vec_t;

endpackage

`default_nettype wire

// File: include/fc_consts.svh
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// array geometry.
`define FC_NUM_LANES   8
`define FC_BANK_DEPTH  84

// data and address widths.
`define FC_W_WIDTH     8
`define FC_PTR_WIDTH   7
`define FC_WADDR_WIDTH 17
`define FC_SEL_LSB     10   // bank field is addr[16:10].
`define FC_SEL_WIDTH   7
`define FC_ACC_WIDTH   24

`endif
